//--- Bender.yml
package:
  name: cp0

sources:
  - target: any(design, sim)
    files:
      - design/common_pkg.sv
      - design/cp0_pkg.sv
      - design/exc_prioritizer.sv
      - design/int_pending.sv
      - design/cp0_regfile.sv
      - design/cp0_top.sv
  - target: sim
    include_dirs:
      - sim
    files:
      - sim/cp0_tb.sv

//--- design/common_pkg.sv
package common_pkg;

	// narrow unsigned fields
	typedef logic u1;
	typedef logic [4:0] u5;
	typedef logic [5:0] u6;
	typedef logic [7:0] u8;

	// full data word, also used for addresses and pc values
	typedef logic [31:0] word_t;

endpackage

//--- design/cp0_pkg.sv
package cp0_pkg;
	import common_pkg::*;

	// status register, MIPS32 bit positions
	typedef struct packed {
		logic [2:0] zero_31_29;
		u1 cu0;
		logic [4:0] zero_27_23;
		u1 bev;
		logic [5:0] zero_21_16;
		u8 im;
		logic [2:0] zero_7_5;
		u1 um;
		u1 zero_3;
		u1 erl;
		u1 exl;
		u1 ie;
	} status_t;

	// cause register
	typedef struct packed {
		u1 bd;
		u1 ti;
		logic [5:0] zero_29_24;
		u1 iv;
		logic [6:0] zero_22_16;
		u8 ip;
		u1 zero_7;
		u5 exc_code;
		logic [1:0] zero_1_0;
	} cause_t;

	// full register state, select 0 of each number
	typedef struct packed {
		word_t index;
		word_t random;
		word_t entry_lo0;
		word_t entry_lo1;
		word_t context_;
		word_t page_mask;
		word_t wired;
		word_t reserved7;
		word_t bad_vaddr;
		word_t count;
		word_t entry_hi;
		word_t compare;
		status_t status;
		cause_t cause;
		word_t epc;
		word_t prid;
		word_t config0;
	} cp0_regs_t;

	// mtc0 data seen as a plain word or through a register layout
	typedef union packed {
		word_t raw;
		status_t st;
		cause_t ca;
	} cp0_wdata_u;

	// exception flags from the memory stage
	typedef struct packed {
		u1 bad_vaddr_f;
		u1 reserve_instr;
		u1 overflow;
		u1 trap;
		u1 syscall;
		u1 adel_d;
		u1 ades_d;
	} excp_type_t;

	typedef enum logic {
		NONE,
		EXCEPTION
	} cp0_type_t;

	// exception codes
	localparam u5 EXCCODE_INT  = 5'd0;
	localparam u5 EXCCODE_ADEL = 5'd4;
	localparam u5 EXCCODE_ADES = 5'd5;
	localparam u5 EXCCODE_SYS  = 5'd8;
	localparam u5 EXCCODE_BP   = 5'd9;
	localparam u5 EXCCODE_RI   = 5'd10;
	localparam u5 EXCCODE_OV   = 5'd12;

	// register numbers, address bits 7:3
	localparam u5 CP0_INDEX     = 5'd0;
	localparam u5 CP0_RANDOM    = 5'd1;
	localparam u5 CP0_ENTRY_LO0 = 5'd2;
	localparam u5 CP0_ENTRY_LO1 = 5'd3;
	localparam u5 CP0_CONTEXT   = 5'd4;
	localparam u5 CP0_PAGE_MASK = 5'd5;
	localparam u5 CP0_WIRED     = 5'd6;
	localparam u5 CP0_RESERVED7 = 5'd7;
	localparam u5 CP0_BAD_VADDR = 5'd8;
	localparam u5 CP0_COUNT     = 5'd9;
	localparam u5 CP0_ENTRY_HI  = 5'd10;
	localparam u5 CP0_COMPARE   = 5'd11;
	localparam u5 CP0_STATUS    = 5'd12;
	localparam u5 CP0_CAUSE     = 5'd13;
	localparam u5 CP0_EPC       = 5'd14;
	localparam u5 CP0_PRID      = 5'd15;
	localparam u5 CP0_CONFIG0   = 5'd16;

endpackage

//--- design/cp0_regfile.sv
`timescale 1ns/100ps

module cp0_regfile import common_pkg::*, cp0_pkg::*; #(
	parameter int COUNT_DIV = 2,
	parameter word_t PRID_VALUE = 32'h0000_4220
) (
	input logic clk,
	input logic reset,
	input u8 ra,
	input u8 wa,
	input word_t wd,
	input u1 valid,
	input u1 is_eret,
	input u1 is_slot,
	input word_t pc,
	input word_t int_pc,
	input cp0_type_t ctype,
	input u1 take_int,
	input u5 exc_code,
	input u1 bad_vaddr_we,
	input word_t bad_vaddr_val,
	input u1 ti_set,
	output word_t rd,
	output word_t epc,
	output status_t status,
	output cause_t cause,
	output u1 count_eq_compare,
	output u1 compare_write,
	output u1 is_intexc,
	output u1 is_exc
);

	localparam int DIV_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;

	cp0_regs_t regs;
	cp0_regs_t regs_nxt;
	cp0_wdata_u wdu;
	cause_t cause_cur;
	logic [DIV_W-1:0] div_cnt;
	u1 tick;
	u1 write_en;
	u1 count_write;

	assign is_exc = (ctype == EXCEPTION);
	assign is_intexc = (ctype == EXCEPTION) || take_int;

	// mtc0 only lands when nothing is taken this cycle
	assign write_en = valid && !is_intexc && (wa[2:0] == 3'b000);
	assign count_write = write_en && (wa[7:3] == CP0_COUNT);
	assign compare_write = write_en && (wa[7:3] == CP0_COMPARE);

	assign count_eq_compare = (regs.count == regs.compare);

	assign wdu.raw = wd;

	// timer bit lives in int_pending
	always_comb begin
		cause_cur = regs.cause;
		cause_cur.ti = ti_set;
	end

	assign status = regs.status;
	assign cause = cause_cur;
	assign epc = regs.epc;

	// count prescaler
	assign tick = (div_cnt == DIV_W'(COUNT_DIV - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
		end else if (tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// mfc0 read, select 0 only
	always_comb begin
		rd = '0;
		if (ra[2:0] == 3'b000) begin
			case (ra[7:3])
				CP0_INDEX:     rd = regs.index;
				CP0_RANDOM:    rd = regs.random;
				CP0_ENTRY_LO0: rd = regs.entry_lo0;
				CP0_ENTRY_LO1: rd = regs.entry_lo1;
				CP0_CONTEXT:   rd = regs.context_;
				CP0_PAGE_MASK: rd = regs.page_mask;
				CP0_WIRED:     rd = regs.wired;
				CP0_RESERVED7: rd = regs.reserved7;
				CP0_BAD_VADDR: rd = regs.bad_vaddr;
				CP0_COUNT:     rd = regs.count;
				CP0_ENTRY_HI:  rd = regs.entry_hi;
				CP0_COMPARE:   rd = regs.compare;
				CP0_STATUS:    rd = regs.status;
				CP0_CAUSE:     rd = cause_cur;
				CP0_EPC:       rd = regs.epc;
				CP0_PRID:      rd = PRID_VALUE;
				CP0_CONFIG0:   rd = regs.config0;
				default:       rd = '0;
			endcase
		end
	end

	always_comb begin
		regs_nxt = regs;
		if (tick && !count_write) begin
			regs_nxt.count = regs.count + 32'd1;
		end

		if (is_intexc) begin
			regs_nxt.cause.exc_code = exc_code;
			if (bad_vaddr_we) begin
				regs_nxt.bad_vaddr = bad_vaddr_val;
			end
			// nested events keep the first return address
			if (!regs.status.exl) begin
				if (take_int) begin
					regs_nxt.epc = int_pc;
				end else if (is_slot) begin
					regs_nxt.epc = pc - 32'd4;
				end else begin
					regs_nxt.epc = pc;
				end
				regs_nxt.cause.bd = is_slot;
			end
			regs_nxt.status.exl = 1'b1;
		end else if (write_en) begin
			case (wa[7:3])
				CP0_INDEX:     regs_nxt.index = wd;
				CP0_ENTRY_LO0: regs_nxt.entry_lo0[29:0] = wd[29:0];
				CP0_ENTRY_LO1: regs_nxt.entry_lo1[29:0] = wd[29:0];
				CP0_CONTEXT:   regs_nxt.context_[31:23] = wd[31:23];
				CP0_PAGE_MASK: regs_nxt.page_mask = wd;
				CP0_WIRED:     regs_nxt.wired = wd;
				CP0_COUNT:     regs_nxt.count = wd;
				CP0_ENTRY_HI: begin
					regs_nxt.entry_hi[31:13] = wd[31:13];
					regs_nxt.entry_hi[7:0] = wd[7:0];
				end
				CP0_COMPARE:   regs_nxt.compare = wd;
				CP0_STATUS: begin
					regs_nxt.status.cu0 = wdu.st.cu0;
					regs_nxt.status.bev = wdu.st.bev;
					regs_nxt.status.im = wdu.st.im;
					regs_nxt.status.um = wdu.st.um;
					regs_nxt.status.erl = wdu.st.erl;
					regs_nxt.status.exl = wdu.st.exl;
					regs_nxt.status.ie = wdu.st.ie;
				end
				CP0_CAUSE: begin
					// only the software interrupt bits and iv are writable
					regs_nxt.cause.iv = wdu.ca.iv;
					regs_nxt.cause.ip[1:0] = wdu.ca.ip[1:0];
				end
				CP0_EPC:       regs_nxt.epc = wd;
				CP0_CONFIG0:   regs_nxt.config0[2:0] = wd[2:0];
				default: begin
				end
			endcase
		end

		if (is_eret) begin
			regs_nxt.status.exl = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			regs <= '0;
		end else begin
			regs <= regs_nxt;
		end
	end

	exl_after_event: assert property (@(posedge clk) disable iff (reset)
		(is_intexc && !is_eret) |=> status.exl)
		else $error("exl not set after a taken exception or interrupt");

	// a nested event leaves the first return address alone
	epc_kept_nested: assert property (@(posedge clk) disable iff (reset)
		(is_intexc && status.exl) |=> $stable(epc))
		else $error("epc changed by a nested exception");

endmodule

//--- design/cp0_top.sv
`timescale 1ns/100ps

module cp0_top import common_pkg::*, cp0_pkg::*; #(
	parameter int COUNT_DIV = 2,
	parameter word_t PRID_VALUE = 32'h0000_4220
) (
	input logic clk,
	input logic reset,
	input u8 ra,
	input u8 wa,
	input word_t wd,
	output word_t rd,
	output word_t epc,
	input u1 valid,
	input u1 is_eret,
	input word_t vaddr,
	input word_t pc,
	input excp_type_t etype,
	input cp0_type_t ctype,
	input u1 inter_valid,
	input u6 ext_int,
	input u1 is_slot,
	input word_t int_pc,
	output u1 is_intexc,
	output u1 is_exc
);

	u1 int_req;
	u1 take_int;
	u1 ti_set;
	u5 exc_code;
	u1 bad_vaddr_we;
	word_t bad_vaddr_val;
	status_t status;
	cause_t cause;
	u1 count_eq_compare;
	u1 compare_write;

	exc_prioritizer exc_prioritizer_inst (
		.etype(etype),
		.int_req(int_req),
		.take_int(take_int),
		.pc(pc),
		.vaddr(vaddr),
		.exc_code(exc_code),
		.bad_vaddr_we(bad_vaddr_we),
		.bad_vaddr_val(bad_vaddr_val)
	);

	int_pending int_pending_inst (
		.clk(clk),
		.reset(reset),
		.status(status),
		.cause(cause),
		.ext_int(ext_int),
		.inter_valid(inter_valid),
		.count_eq_compare(count_eq_compare),
		.compare_write(compare_write),
		.int_req(int_req),
		.take_int(take_int),
		.ti_set(ti_set)
	);

	cp0_regfile #(
		.COUNT_DIV(COUNT_DIV),
		.PRID_VALUE(PRID_VALUE)
	) cp0_regfile_inst (
		.clk(clk),
		.reset(reset),
		.ra(ra),
		.wa(wa),
		.wd(wd),
		.valid(valid),
		.is_eret(is_eret),
		.is_slot(is_slot),
		.pc(pc),
		.int_pc(int_pc),
		.ctype(ctype),
		.take_int(take_int),
		.exc_code(exc_code),
		.bad_vaddr_we(bad_vaddr_we),
		.bad_vaddr_val(bad_vaddr_val),
		.ti_set(ti_set),
		.rd(rd),
		.epc(epc),
		.status(status),
		.cause(cause),
		.count_eq_compare(count_eq_compare),
		.compare_write(compare_write),
		.is_intexc(is_intexc),
		.is_exc(is_exc)
	);

endmodule

//--- design/exc_prioritizer.sv
`timescale 1ns/100ps

module exc_prioritizer import common_pkg::*, cp0_pkg::*; (
	input excp_type_t etype,
	input u1 int_req,
	input u1 take_int,
	input word_t pc,
	input word_t vaddr,
	output u5 exc_code,
	output u1 bad_vaddr_we,
	output word_t bad_vaddr_val
);

	// one cause wins, interrupts first, then in pipeline order
	always_comb begin
		exc_code = EXCCODE_INT;
		bad_vaddr_we = 1'b0;
		bad_vaddr_val = vaddr;
		if (int_req || take_int) begin
			exc_code = EXCCODE_INT;
		end else if (etype.bad_vaddr_f) begin
			// fetch fault, the pc itself is the bad address
			exc_code = EXCCODE_ADEL;
			bad_vaddr_we = 1'b1;
			bad_vaddr_val = pc;
		end else if (etype.reserve_instr) begin
			exc_code = EXCCODE_RI;
		end else if (etype.overflow) begin
			exc_code = EXCCODE_OV;
		end else if (etype.trap) begin
			exc_code = EXCCODE_BP;
		end else if (etype.syscall) begin
			exc_code = EXCCODE_SYS;
		end else if (etype.adel_d) begin
			exc_code = EXCCODE_ADEL;
			bad_vaddr_we = 1'b1;
			bad_vaddr_val = vaddr;
		end else if (etype.ades_d) begin
			exc_code = EXCCODE_ADES;
			bad_vaddr_we = 1'b1;
			bad_vaddr_val = vaddr;
		end
	end

endmodule

//--- design/int_pending.sv
`timescale 1ns/100ps

module int_pending import common_pkg::*, cp0_pkg::*; (
	input logic clk,
	input logic reset,
	input status_t status,
	input cause_t cause,
	input u6 ext_int,
	input u1 inter_valid,
	input u1 count_eq_compare,
	input u1 compare_write,
	output u1 int_req,
	output u1 take_int,
	output u1 ti_set
);

	u8 pending;
	u1 int_saved;
	u1 ti_q;

	// hardware lines on 7:2, software on 1:0, timer shares line 7
	assign pending = {ext_int[5] | cause.ti, ext_int[4:0], cause.ip[1:0]};

	assign int_req = status.ie && !status.exl && (|(pending & status.im));

	// a request seen while the pipeline was busy is still taken later
	assign take_int = (int_req || int_saved) && inter_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			int_saved <= 1'b0;
		end else if (int_req && !inter_valid) begin
			int_saved <= 1'b1;
		end else if (inter_valid) begin
			int_saved <= 1'b0;
		end
	end

	// timer bit sticks until compare is rewritten
	always_ff @(posedge clk) begin
		if (reset) begin
			ti_q <= 1'b0;
		end else if (compare_write) begin
			ti_q <= 1'b0;
		end else if (count_eq_compare) begin
			ti_q <= 1'b1;
		end
	end

	assign ti_set = ti_q;

	// a request held off by a busy pipeline is taken once it can accept
	deferred_taken: assert property (@(posedge clk) disable iff (reset)
		(int_req && !inter_valid) |=> (!inter_valid || take_int))
		else $error("deferred interrupt not taken when the pipeline accepted");

endmodule

//--- sim/cp0_tb_vectors.svh
// one call per table row, in the order the rows are applied
// test number first, then addresses, data and expected read value

// 1: write masks (compare first, so the timer bit clears)
write_row(1, 8'h58, 32'hffff_ffff);
write_row(1, 8'h10, 32'hffff_ffff);
read_row(1, 8'h10, 32'h3fff_ffff);
write_row(1, 8'h20, 32'hffff_ffff);
read_row(1, 8'h20, 32'hff80_0000);
write_row(1, 8'h50, 32'hffff_ffff);
read_row(1, 8'h50, 32'hffff_e0ff);
write_row(1, 8'h60, 32'hffff_ffff);
read_row(1, 8'h60, 32'h1040_ff17);
write_row(1, 8'h68, 32'hffff_ffff);
read_row(1, 8'h68, 32'h0080_0300);
write_row(1, 8'h80, 32'hffff_ffff);
read_row(1, 8'h80, 32'h0000_0007);
read_row(1, 8'h78, 32'h0000_4220);
read_row(1, 8'h61, 32'h0000_0000);
write_row(1, 8'h68, 32'h0000_0000);
write_row(1, 8'h60, 32'h0000_0000);
read_row(1, 8'h60, 32'h0000_0000);

// 2: overflow, then a nested trap, then eret
exc_row(2, ET_OVERFLOW, 32'h0040_0100, 32'h0, 1'b0);
epc_row(2, 32'h0040_0100);
read_row(2, 8'h68, 32'h0000_0030);
read_row(2, 8'h60, 32'h0000_0002);
exc_row(2, ET_TRAP, 32'h0040_0200, 32'h0, 1'b0);
read_row(2, 8'h68, 32'h0000_0024);
epc_row(2, 32'h0040_0100);
eret_row(2);
read_row(2, 8'h60, 32'h0000_0000);

// 3: delay slot, syscall beats a store fault, then a fetch fault
eret_row(3);
exc_row(3, ET_SYSCALL | ET_ADES, 32'h0040_0304, 32'h1000_0003, 1'b1);
read_row(3, 8'h68, 32'h8000_0020);
epc_row(3, 32'h0040_0300);
read_row(3, 8'h40, 32'h0000_0000);
eret_row(3);
exc_row(3, ET_FETCH | ET_ADEL, 32'h0040_0401, 32'h2000_0001, 1'b0);
read_row(3, 8'h68, 32'h0000_0010);
read_row(3, 8'h40, 32'h0040_0401);
eret_row(3);

// 4: software interrupt 0
write_row(4, 8'h60, 32'h0000_0101);
write_row(4, 8'h68, 32'h0000_0100);
int_row(4, 6'b000000, 1'b1, 32'h0040_0500, 1'b1);
epc_row(4, 32'h0040_0500);
read_row(4, 8'h68, 32'h0000_0100);
write_row(4, 8'h68, 32'h0000_0000);

// 5: ext_int[0] arrives while the pipeline is busy
write_row(5, 8'h60, 32'h0000_0401);
int_row(5, 6'b000001, 1'b0, 32'h0040_05f0, 1'b0);
int_row(5, 6'b000000, 1'b1, 32'h0040_0600, 1'b1);
epc_row(5, 32'h0040_0600);
write_row(5, 8'h60, 32'h0000_0000);

// 6: count, k = 3
write_row(6, 8'h48, 32'd100);
read_row(6, 8'h48, 32'd100);
repeat (6) idle_row(6);
read_row(6, 8'h48, 32'd103);

//--- sim/cp0_tb.sv
`timescale 1ns/100ps

module cp0_tb import common_pkg::*, cp0_pkg::*;;

	localparam logic [6:0] ET_FETCH    = 7'b100_0000;
	localparam logic [6:0] ET_OVERFLOW = 7'b001_0000;
	localparam logic [6:0] ET_TRAP     = 7'b000_1000;
	localparam logic [6:0] ET_SYSCALL  = 7'b000_0100;
	localparam logic [6:0] ET_ADEL     = 7'b000_0010;
	localparam logic [6:0] ET_ADES     = 7'b000_0001;

	typedef struct {
		int test;
		u8 ra;
		u8 wa;
		word_t wd;
		logic valid;
		logic exc;
		logic [6:0] etype;
		word_t pc;
		word_t vaddr;
		logic is_slot;
		word_t int_pc;
		u6 ext_int;
		logic inter_valid;
		logic is_eret;
		logic chk_rd;
		word_t exp_rd;
		logic exp_intexc;
		logic exp_exc;
		logic chk_epc;
		word_t exp_epc;
	} row_t;

	logic clk;
	logic reset;
	u8 ra;
	u8 wa;
	word_t wd;
	word_t rd;
	word_t epc;
	u1 valid;
	u1 is_eret;
	word_t vaddr;
	word_t pc;
	excp_type_t etype;
	cp0_type_t ctype;
	u1 inter_valid;
	u6 ext_int;
	u1 is_slot;
	word_t int_pc;
	u1 is_intexc;
	u1 is_exc;

	row_t rows[$];
	string test_names[1:6];
	int test_errs;
	int total_errs;
	int tests_ok;
	int tests_bad;
	int cycles;

	cp0_top cp0_top_inst (
		.clk(clk),
		.reset(reset),
		.ra(ra),
		.wa(wa),
		.wd(wd),
		.rd(rd),
		.epc(epc),
		.valid(valid),
		.is_eret(is_eret),
		.vaddr(vaddr),
		.pc(pc),
		.etype(etype),
		.ctype(ctype),
		.inter_valid(inter_valid),
		.ext_int(ext_int),
		.is_slot(is_slot),
		.int_pc(int_pc),
		.is_intexc(is_intexc),
		.is_exc(is_exc)
	);

	always #20 clk = ~clk;

	// quiet cycle, reads index which is never written
	function automatic row_t blank_row(int t);
		row_t r;
		r = '{default: '0};
		r.test = t;
		return r;
	endfunction

	task automatic idle_row(int t);
		rows.push_back(blank_row(t));
	endtask

	task automatic write_row(int t, u8 a, word_t d);
		row_t r;
		r = blank_row(t);
		r.wa = a;
		r.wd = d;
		r.valid = 1'b1;
		rows.push_back(r);
	endtask

	task automatic read_row(int t, u8 a, word_t expected);
		row_t r;
		r = blank_row(t);
		r.ra = a;
		r.chk_rd = 1'b1;
		r.exp_rd = expected;
		rows.push_back(r);
	endtask

	// read epc through both rd and the epc port
	task automatic epc_row(int t, word_t expected);
		row_t r;
		r = blank_row(t);
		r.ra = 8'h70;
		r.chk_rd = 1'b1;
		r.exp_rd = expected;
		r.chk_epc = 1'b1;
		r.exp_epc = expected;
		rows.push_back(r);
	endtask

	task automatic exc_row(int t, logic [6:0] et, word_t p, word_t va, logic slot);
		row_t r;
		r = blank_row(t);
		r.exc = 1'b1;
		r.etype = et;
		r.pc = p;
		r.vaddr = va;
		r.is_slot = slot;
		r.exp_intexc = 1'b1;
		r.exp_exc = 1'b1;
		rows.push_back(r);
	endtask

	task automatic eret_row(int t);
		row_t r;
		r = blank_row(t);
		r.is_eret = 1'b1;
		rows.push_back(r);
	endtask

	task automatic int_row(int t, u6 lines, logic iv, word_t ipc, logic taken);
		row_t r;
		r = blank_row(t);
		r.ext_int = lines;
		r.inter_valid = iv;
		r.int_pc = ipc;
		r.exp_intexc = taken;
		rows.push_back(r);
	endtask

	task automatic build_table();
		`include "cp0_tb_vectors.svh"
	endtask

	task automatic check(string name, word_t actual, word_t expected);
		if (actual !== expected) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
			test_errs++;
			total_errs++;
		end
	endtask

	task automatic close_test(int t);
		if (test_errs == 0) begin
			$display("test %0d %s: ok", t, test_names[t]);
			tests_ok++;
		end else begin
			$display("test %0d %s: %0d errors", t, test_names[t], test_errs);
			tests_bad++;
		end
		test_errs = 0;
	endtask

	// limit covers reset, every row and some slack
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > rows.size() + 60) begin
			$display("timeout: the table did not finish in time");
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		row_t r;
		clk = 1'b0;
		reset = 1'b1;
		ra = '0;
		wa = '0;
		wd = '0;
		valid = 1'b0;
		is_eret = 1'b0;
		vaddr = '0;
		pc = '0;
		etype = '0;
		ctype = NONE;
		inter_valid = 1'b0;
		ext_int = '0;
		is_slot = 1'b0;
		int_pc = '0;
		cycles = 0;
		test_errs = 0;
		total_errs = 0;
		tests_ok = 0;
		tests_bad = 0;
		test_names[1] = "write masks";
		test_names[2] = "exception recording";
		test_names[3] = "delay slot and priority";
		test_names[4] = "software interrupt";
		test_names[5] = "deferred interrupt";
		test_names[6] = "count";
		build_table();

		repeat (10) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < rows.size(); i++) begin
			r = rows[i];
			@(posedge clk);
			ra <= r.ra;
			wa <= r.wa;
			wd <= r.wd;
			valid <= r.valid;
			ctype <= r.exc ? EXCEPTION : NONE;
			etype <= excp_type_t'(r.etype);
			pc <= r.pc;
			vaddr <= r.vaddr;
			is_slot <= r.is_slot;
			int_pc <= r.int_pc;
			ext_int <= r.ext_int;
			inter_valid <= r.inter_valid;
			is_eret <= r.is_eret;
			// outputs settle by the falling edge
			@(negedge clk);
			if (r.chk_rd) begin
				check("rd", rd, r.exp_rd);
			end
			check("is_intexc", word_t'(is_intexc), word_t'(r.exp_intexc));
			check("is_exc", word_t'(is_exc), word_t'(r.exp_exc));
			if (r.chk_epc) begin
				check("epc", epc, r.exp_epc);
			end
			if (i == rows.size() - 1 || rows[i + 1].test != r.test) begin
				close_test(r.test);
			end
		end

		$display("tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
		if (total_errs == 0 && tests_bad == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+sim
design/common_pkg.sv
design/cp0_pkg.sv
design/exc_prioritizer.sv
design/int_pending.sv
design/cp0_regfile.sv
design/cp0_top.sv
sim/cp0_tb.sv
